//--- build.f
+incdir+include
rtl/rv32_pkg.sv
rtl/pipe_ctrl_if.sv
rtl/pipeline_control.sv
rtl/rv32_fetch_stage.sv
rtl/rv32_decode_stage.sv
rtl/rv32_exec_stage.sv
rtl/rv32_mem_wb_stage.sv
rtl/rv32_register_file.sv
rtl/rv32_core.sv
testbench/rv32_core_chk.sv
testbench/rv32_core_tb.sv

//--- include/rv32_macros.svh
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Address of the first instruction fetched after reset
`define RV32_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define RV32_NOP_INSTR 32'h0000_0013

// Architectural registers, x0 included
`define RV32_REG_COUNT 32

`endif

//--- rtl/pipe_ctrl_if.sv
`default_nettype none

interface pipe_ctrl_if;

    // Stall requests raised by the stages
    logic fetch_stall;
    logic dec_stall;
    logic mem_stall;

    // Resolved holds and the jump flush
    logic hold_fetch;
    logic hold_decode;
    logic hold_exec;
    logic flush;

    modport control (
        input  fetch_stall, dec_stall, mem_stall,
        output hold_fetch, hold_decode, hold_exec, flush
    );

    modport stage (
        output fetch_stall, dec_stall, mem_stall,
        input  hold_fetch, hold_decode, hold_exec, flush
    );

endinterface

`default_nettype wire

//--- rtl/pipeline_control.sv
`default_nettype none

module pipeline_control #(
    parameter rv32_pkg::rv32_word RESET_PC = '0
) (
    input  logic               clk,
    input  logic               resetn,
    pipe_ctrl_if.control       ctrl,
    input  logic               do_jump,
    input  rv32_pkg::rv32_word jump_addr,
    output rv32_pkg::rv32_word pc
);
    import rv32_pkg::*;

    rv32_word next_pc;

    // A waiting memory stage freezes the whole pipe, including a
    // jump that sits in execute
    always_comb begin
        ctrl.hold_exec = ctrl.mem_stall;
        ctrl.hold_decode = ctrl.mem_stall | ctrl.dec_stall;
        ctrl.hold_fetch = ctrl.mem_stall | ctrl.dec_stall;
        ctrl.flush = do_jump & ~ctrl.mem_stall;
    end

    always_comb begin
        if (!resetn) begin
            next_pc = RESET_PC;
        end else if (ctrl.flush) begin
            next_pc = jump_addr;
        end else if (ctrl.fetch_stall) begin
            // Fetch has not taken this PC yet
            next_pc = pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        pc <= next_pc;
    end

endmodule

`default_nettype wire

//--- rtl/rv32_core.sv
`default_nettype none

`include "rv32_macros.svh"

module rv32_core (
    input  logic               clk,
    input  logic               resetn,
    // Instruction port
    output logic               instr_valid,
    input  logic               instr_ready,
    output rv32_pkg::rv32_word instr_addr,
    input  logic               instr_rvalid,
    input  rv32_pkg::rv32_word instr_rdata,
    // Data port
    output logic               data_valid,
    input  logic               data_ready,
    output logic               data_write,
    output rv32_pkg::rv32_word data_addr,
    output rv32_pkg::rv32_word data_wdata,
    input  logic               data_rvalid,
    input  rv32_pkg::rv32_word data_rdata
);
    import rv32_pkg::*;

    rv32_word      pc;
    logic          do_jump;
    rv32_word      jump_addr;
    fetch_decode_t fd_buff;
    decode_exec_t  de_buff;
    exec_mem_t     em_buff;

    // Register file ports
    rv_reg_id_t    rs1;
    rv_reg_id_t    rs2;
    rv32_word      reg1;
    rv32_word      reg2;
    logic          wb_we;
    rv_reg_id_t    wb_rd;
    rv32_word      wb_data;

    pipe_ctrl_if ctrl_bus ();

    pipeline_control #(.RESET_PC(`RV32_RESET_PC)) control (
        .clk(clk), .resetn(resetn), .ctrl(ctrl_bus),
        .do_jump(do_jump), .jump_addr(jump_addr), .pc(pc)
    );

    rv32_fetch_stage fetch_stage (
        .clk(clk), .resetn(resetn), .ctrl(ctrl_bus), .pc(pc),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_addr(instr_addr),
        .instr_rvalid(instr_rvalid), .instr_rdata(instr_rdata),
        .fd_buff(fd_buff)
    );

    rv32_decode_stage decode_stage (
        .clk(clk), .resetn(resetn), .ctrl(ctrl_bus),
        .fd_buff(fd_buff), .de_buff(de_buff), .em_buff(em_buff),
        .rs1(rs1), .rs2(rs2), .reg1(reg1), .reg2(reg2)
    );

    rv32_exec_stage exec_stage (
        .clk(clk), .resetn(resetn), .ctrl(ctrl_bus),
        .de_buff(de_buff), .em_buff(em_buff),
        .do_jump(do_jump), .jump_addr(jump_addr)
    );

    rv32_mem_wb_stage mem_wb_stage (
        .clk(clk), .resetn(resetn), .ctrl(ctrl_bus), .em_buff(em_buff),
        .data_valid(data_valid), .data_ready(data_ready), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_rvalid(data_rvalid), .data_rdata(data_rdata),
        .reg_write(wb_we), .rd(wb_rd), .wb_data(wb_data)
    );

    rv32_register_file rf (
        .clk(clk), .resetn(resetn),
        .r1(rs1), .r2(rs2), .o1(reg1), .o2(reg2),
        .write(wb_we), .rw(wb_rd), .d(wb_data)
    );

endmodule

`default_nettype wire

//--- rtl/rv32_decode_stage.sv
`default_nettype none

`include "rv32_macros.svh"

module rv32_decode_stage (
    input  logic                    clk,
    input  logic                    resetn,
    pipe_ctrl_if.stage              ctrl,
    input  rv32_pkg::fetch_decode_t fd_buff,
    output rv32_pkg::decode_exec_t  de_buff,
    input  rv32_pkg::exec_mem_t     em_buff,
    output rv32_pkg::rv_reg_id_t    rs1,
    output rv32_pkg::rv_reg_id_t    rs2,
    input  rv32_pkg::rv32_word      reg1,
    input  rv32_pkg::rv32_word      reg2
);
    import rv32_pkg::*;

    rv32_word     instr;
    opcode_e      opcode;
    logic [2:0]   funct3;
    logic         use_rs1;
    logic         use_rs2;
    logic         read_rs1;
    logic         read_rs2;
    logic         hazard_ex;
    logic         hazard_mem;
    decode_exec_t dec;

    // An empty slot decodes as a NOP
    assign instr = fd_buff.valid ? fd_buff.instr : `RV32_NOP_INSTR;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        dec = '0;
        dec.valid = fd_buff.valid;
        dec.pc = fd_buff.pc;
        dec.alu_op = ALU_ADD;
        dec.rs1_val = reg1;
        dec.rs2_val = reg2;
        dec.rd = instr[11:7];
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010: dec.alu_op = ALU_SLT;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                use_rs1 = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:20]};
                dec.reg_write = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec.alu_op = ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.imm = {instr[31:12], 12'b0};
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                use_rs1 = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:20]};
                dec.reg_write = (funct3 == 3'b010);
                dec.mem_read = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                dec.branch = (funct3[2:1] == 2'b00);
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
                dec.jump = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Interlock against older writers still in flight
    assign read_rs1 = use_rs1 && (rs1 != '0);
    assign read_rs2 = use_rs2 && (rs2 != '0);
    assign hazard_ex = de_buff.valid && de_buff.reg_write &&
                       ((read_rs1 && rs1 == de_buff.rd) || (read_rs2 && rs2 == de_buff.rd));
    assign hazard_mem = em_buff.valid && em_buff.reg_write &&
                        ((read_rs1 && rs1 == em_buff.rd) || (read_rs2 && rs2 == em_buff.rd));
    assign ctrl.dec_stall = fd_buff.valid && (hazard_ex || hazard_mem);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            de_buff.valid <= 1'b0;
        end else if (ctrl.flush) begin
            de_buff.valid <= 1'b0;
        end else if (!ctrl.hold_exec) begin
            if (ctrl.hold_decode) begin
                // Bubble into execute
                de_buff.valid <= 1'b0;
            end else begin
                de_buff <= dec;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv32_exec_stage.sv
`default_nettype none

module rv32_exec_stage (
    input  logic                   clk,
    input  logic                   resetn,
    pipe_ctrl_if.stage             ctrl,
    input  rv32_pkg::decode_exec_t de_buff,
    output rv32_pkg::exec_mem_t    em_buff,
    output logic                   do_jump,
    output rv32_pkg::rv32_word     jump_addr
);
    import rv32_pkg::*;

    rv32_word alu_a;
    rv32_word alu_b;
    rv32_word alu_out;
    rv32_word link_addr;
    logic     operands_equal;
    logic     taken;

    assign alu_a = de_buff.rs1_val;
    assign alu_b = de_buff.use_imm ? de_buff.imm : de_buff.rs2_val;

    always_comb begin
        case (de_buff.alu_op)
            ALU_ADD: alu_out = alu_a + alu_b;
            ALU_SUB: alu_out = alu_a - alu_b;
            ALU_AND: alu_out = alu_a & alu_b;
            ALU_OR: alu_out = alu_a | alu_b;
            ALU_XOR: alu_out = alu_a ^ alu_b;
            ALU_SLT: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_PASS_B: alu_out = alu_b;
            default: alu_out = '0;
        endcase
    end

    // BEQ and BNE compare the register values directly
    assign operands_equal = (de_buff.rs1_val == de_buff.rs2_val);
    assign taken = de_buff.branch && (de_buff.branch_ne ? !operands_equal : operands_equal);
    assign do_jump = de_buff.valid && (de_buff.jump || taken);
    assign jump_addr = de_buff.pc + de_buff.imm;
    assign link_addr = de_buff.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            em_buff.valid <= 1'b0;
        end else if (!ctrl.hold_exec) begin
            em_buff.valid <= de_buff.valid;
            em_buff.alu_result <= de_buff.jump ? link_addr : alu_out;
            em_buff.store_data <= de_buff.rs2_val;
            em_buff.rd <= de_buff.rd;
            em_buff.reg_write <= de_buff.reg_write;
            em_buff.mem_read <= de_buff.mem_read;
            em_buff.mem_write <= de_buff.mem_write;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv32_fetch_stage.sv
`default_nettype none

`include "rv32_macros.svh"

module rv32_fetch_stage (
    input  logic                    clk,
    input  logic                    resetn,
    pipe_ctrl_if.stage              ctrl,
    input  rv32_pkg::rv32_word      pc,
    output logic                    instr_valid,
    input  logic                    instr_ready,
    output rv32_pkg::rv32_word      instr_addr,
    input  logic                    instr_rvalid,
    input  rv32_pkg::rv32_word      instr_rdata,
    output rv32_pkg::fetch_decode_t fd_buff
);
    import rv32_pkg::*;

    logic outstanding;
    logic drop;
    logic issue;
    logic accept;

    // Only ask when the buffer is sure to be free for the response
    assign issue = !instr_valid && !outstanding && !ctrl.flush &&
                   (!fd_buff.valid || !ctrl.hold_fetch);
    assign accept = instr_rvalid && !drop && !ctrl.flush;
    assign ctrl.fetch_stall = !issue;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            instr_valid <= 1'b0;
            outstanding <= 1'b0;
            drop <= 1'b0;
        end else begin
            if (issue) begin
                instr_valid <= 1'b1;
                instr_addr <= pc;
            end else if (instr_valid && instr_ready) begin
                instr_valid <= 1'b0;
            end
            if (instr_valid && instr_ready) begin
                outstanding <= 1'b1;
            end else if (instr_rvalid) begin
                outstanding <= 1'b0;
            end
            // Response of a request that belongs to the old path
            drop <= (drop && !instr_rvalid) ||
                    (ctrl.flush && (instr_valid || (outstanding && !instr_rvalid)));
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_buff.valid <= 1'b0;
        end else if (accept) begin
            fd_buff.valid <= 1'b1;
            fd_buff.pc <= instr_addr;
            fd_buff.instr <= instr_rdata;
        end else if (ctrl.flush || !ctrl.hold_fetch) begin
            fd_buff.valid <= 1'b0;
            fd_buff.instr <= `RV32_NOP_INSTR;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv32_mem_wb_stage.sv
`default_nettype none

module rv32_mem_wb_stage (
    input  logic                 clk,
    input  logic                 resetn,
    pipe_ctrl_if.stage           ctrl,
    input  rv32_pkg::exec_mem_t  em_buff,
    // Data port
    output logic                 data_valid,
    input  logic                 data_ready,
    output logic                 data_write,
    output rv32_pkg::rv32_word   data_addr,
    output rv32_pkg::rv32_word   data_wdata,
    input  logic                 data_rvalid,
    input  rv32_pkg::rv32_word   data_rdata,
    // Writeback
    output logic                 reg_write,
    output rv32_pkg::rv_reg_id_t rd,
    output rv32_pkg::rv32_word   wb_data
);
    import rv32_pkg::*;

    logic mem_access;
    logic sent;
    logic response;

    assign mem_access = em_buff.valid && (em_buff.mem_read || em_buff.mem_write);
    assign response = sent && data_rvalid;

    // Request fields come straight from the held buffer, so they
    // stay stable until the transfer
    assign data_valid = mem_access && !sent;
    assign data_write = em_buff.mem_write;
    assign data_addr = em_buff.alu_result;
    assign data_wdata = em_buff.store_data;
    assign ctrl.mem_stall = mem_access && !response;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sent <= 1'b0;
        end else if (data_valid && data_ready) begin
            sent <= 1'b1;
        end else if (data_rvalid) begin
            sent <= 1'b0;
        end
    end

    // Loads write in the response cycle, everything else right away
    assign reg_write = em_buff.valid && em_buff.reg_write && (!em_buff.mem_read || response);
    assign rd = em_buff.rd;
    assign wb_data = em_buff.mem_read ? data_rdata : em_buff.alu_result;

endmodule

`default_nettype wire

//--- rtl/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] rv32_word;
    typedef logic [4:0] rv_reg_id_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        rv32_word pc;
        rv32_word instr;
    } fetch_decode_t;

    typedef struct packed {
        logic       valid;
        rv32_word   pc;
        alu_op_e    alu_op;
        rv32_word   rs1_val;
        rv32_word   rs2_val;
        rv32_word   imm;
        rv_reg_id_t rd;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       branch_ne;
        logic       jump;
        logic       use_imm;
    } decode_exec_t;

    // Store data rides along with the address from execute
    typedef struct packed {
        logic       valid;
        rv32_word   alu_result;
        rv32_word   store_data;
        rv_reg_id_t rd;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
    } exec_mem_t;

endpackage

`default_nettype wire

//--- rtl/rv32_register_file.sv
`default_nettype none

`include "rv32_macros.svh"

module rv32_register_file (
    input  logic                 clk,
    input  logic                 resetn,
    input  rv32_pkg::rv_reg_id_t r1,
    input  rv32_pkg::rv_reg_id_t r2,
    output rv32_pkg::rv32_word   o1,
    output rv32_pkg::rv32_word   o2,
    input  logic                 write,
    input  rv32_pkg::rv_reg_id_t rw,
    input  rv32_pkg::rv32_word   d
);
    import rv32_pkg::*;

    // x0 has no storage
    rv32_word regs [1:`RV32_REG_COUNT-1];

    function automatic rv32_word read_reg(input rv_reg_id_t r);
        if (r == '0) begin
            return '0;
        end else if (write && rw == r) begin
            // Same-cycle write goes straight through
            return d;
        end
        return regs[r];
    endfunction

    always_comb begin
        o1 = read_reg(r1);
        o2 = read_reg(r2);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < `RV32_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rw != '0) begin
            regs[rw] <= d;
        end
    end

endmodule

`default_nettype wire

//--- testbench/rv32_core_chk.sv
`default_nettype none

module rv32_core_chk (
    input logic               clk,
    input logic               resetn,
    input logic               instr_valid,
    input logic               instr_ready,
    input rv32_pkg::rv32_word instr_addr,
    input logic               instr_rvalid,
    input logic               data_valid,
    input logic               data_ready,
    input logic               data_write,
    input rv32_pkg::rv32_word data_addr,
    input rv32_pkg::rv32_word data_wdata,
    input logic               data_rvalid
);
    import rv32_pkg::*;

    logic instr_pending;
    logic data_pending;
    int   failures = 0;

    // Requests accepted but not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            instr_pending <= 1'b0;
            data_pending <= 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                instr_pending <= 1'b1;
            end else if (instr_rvalid) begin
                instr_pending <= 1'b0;
            end
            if (data_valid && data_ready) begin
                data_pending <= 1'b1;
            end else if (data_rvalid) begin
                data_pending <= 1'b0;
            end
        end
    end

    instr_hold: assert property (@(posedge clk) disable iff (!resetn)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr_addr))
    else begin
        $error("instr_valid dropped or instr_addr changed before the transfer");
        failures++;
    end

    data_hold: assert property (@(posedge clk) disable iff (!resetn)
        data_valid && !data_ready |=> data_valid && $stable(data_addr) &&
        $stable(data_write) && $stable(data_wdata))
    else begin
        $error("data_valid dropped or a data request field changed before the transfer");
        failures++;
    end

    instr_resp_owned: assert property (@(posedge clk) disable iff (!resetn)
        instr_rvalid |-> instr_pending)
    else begin
        $error("instr_rvalid seen with no instruction request outstanding");
        failures++;
    end

    data_resp_owned: assert property (@(posedge clk) disable iff (!resetn)
        data_rvalid |-> data_pending)
    else begin
        $error("data_rvalid seen with no data request outstanding");
        failures++;
    end

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> !instr_valid && !data_valid)
    else begin
        $error("A request valid was high on the first cycle after reset");
        failures++;
    end

endmodule

`default_nettype wire

//--- testbench/rv32_core_tb.sv
`default_nettype none

`include "rv32_macros.svh"

module rv32_core_tb;
    import rv32_pkg::*;

    localparam int PATTERN_WORDS = 128;
    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 64;
    localparam int IDLE_CYCLES = 20;
    localparam int CYCLES_PER_WORD = 200;

    logic        clk;
    logic        resetn;
    logic        instr_valid;
    logic        instr_ready;
    rv32_word    instr_addr;
    logic        instr_rvalid;
    rv32_word    instr_rdata;
    logic        data_valid;
    logic        data_ready;
    logic        data_write;
    rv32_word    data_addr;
    rv32_word    data_wdata;
    logic        data_rvalid;
    rv32_word    data_rdata;

    rv32_word    patterns [0:PATTERN_WORDS-1];
    rv32_word    rom [0:ROM_WORDS-1];
    rv32_word    ram [0:RAM_WORDS-1];
    int          prog_len = 0;
    int          store_count;
    int          store_base;
    int          stores_seen;
    logic        first_fetch_done;
    logic [31:0] rng_state;

    // Response state of the two memory models
    logic        instr_busy;
    int          instr_wait;
    rv32_word    instr_resp;
    logic        data_busy;
    int          data_wait;
    rv32_word    data_resp;

    rv32_core rv32_core_i (
        .clk(clk), .resetn(resetn),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_addr(instr_addr),
        .instr_rvalid(instr_rvalid), .instr_rdata(instr_rdata),
        .data_valid(data_valid), .data_ready(data_ready), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_rvalid(data_rvalid), .data_rdata(data_rdata)
    );

    bind rv32_core rv32_core_chk protocol_chk (
        .clk(clk), .resetn(resetn),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_addr(instr_addr),
        .instr_rvalid(instr_rvalid),
        .data_valid(data_valid), .data_ready(data_ready), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_rvalid(data_rvalid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic compare_word(input string name, input rv32_word actual,
                                input rv32_word expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    // Stores must arrive in program order
    task automatic check_store(input rv32_word addr, input rv32_word wdata);
        if (stores_seen >= store_count) begin
            abort_run($sformatf("Unexpected extra store to address %h at time %0t",
                                addr, $time));
        end
        compare_word("data_addr", addr, patterns[store_base + 2 * stores_seen]);
        compare_word("data_wdata", wdata, patterns[store_base + 2 * stores_seen + 1]);
        stores_seen++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Both memory models in one process so the random sequence is fixed
    always @(posedge clk) begin
        if (!resetn) begin
            instr_busy = 1'b0;
            data_busy = 1'b0;
        end else begin
            if (instr_rvalid) begin
                instr_busy = 1'b0;
            end else if (instr_busy && instr_wait > 0) begin
                instr_wait--;
            end
            if (instr_valid && instr_ready) begin
                if (!first_fetch_done) begin
                    compare_word("instr_addr", instr_addr, `RV32_RESET_PC);
                end
                first_fetch_done = 1'b1;
                if (instr_addr >= 4 * ROM_WORDS || instr_addr[1:0] != 2'b00) begin
                    abort_run($sformatf("Instruction fetch from bad address %h", instr_addr));
                end
                instr_resp = rom[instr_addr[7:2]];
                instr_busy = 1'b1;
                rng_state = xorshift32(rng_state);
                instr_wait = rng_state % 3;
            end
            if (data_rvalid) begin
                data_busy = 1'b0;
            end else if (data_busy && data_wait > 0) begin
                data_wait--;
            end
            if (data_valid && data_ready) begin
                if (data_addr >= 4 * RAM_WORDS || data_addr[1:0] != 2'b00) begin
                    abort_run($sformatf("Data access to bad address %h", data_addr));
                end
                if (data_write) begin
                    check_store(data_addr, data_wdata);
                    ram[data_addr[7:2]] = data_wdata;
                    data_resp = '0;
                end else begin
                    data_resp = ram[data_addr[7:2]];
                end
                data_busy = 1'b1;
                rng_state = xorshift32(rng_state);
                data_wait = rng_state % 3;
            end
        end
        #1;
        rng_state = xorshift32(rng_state);
        instr_ready = (rng_state[1:0] != 2'b00);
        rng_state = xorshift32(rng_state);
        data_ready = (rng_state[1:0] != 2'b00);
        instr_rvalid = instr_busy && (instr_wait == 0);
        instr_rdata = instr_rvalid ? instr_resp : '0;
        data_rvalid = data_busy && (data_wait == 0);
        data_rdata = data_rvalid ? data_resp : '0;
    end

    always @(negedge clk) begin
        if (rv32_core_i.protocol_chk.failures != 0) begin
            abort_run("A memory port protocol assertion failed");
        end
    end

    initial begin
        int idx;
        resetn = 1'b0;
        instr_ready = 1'b0;
        instr_rvalid = 1'b0;
        instr_rdata = '0;
        data_ready = 1'b0;
        data_rvalid = 1'b0;
        data_rdata = '0;
        rng_state = 32'h61b0_d097;
        stores_seen = 0;
        first_fetch_done = 1'b0;
        for (idx = 0; idx < PATTERN_WORDS; idx++) begin
            patterns[idx] = '0;
        end
        $readmemh("testbench/rv32_patterns.txt", patterns);
        store_count = patterns[1];
        store_base = 2 + patterns[0];
        if (patterns[0] == 0 || patterns[0] > ROM_WORDS ||
            store_base + 2 * store_count > PATTERN_WORDS) begin
            abort_run("The patterns file is missing or its header is malformed");
        end
        for (idx = 0; idx < ROM_WORDS; idx++) begin
            rom[idx] = (idx < patterns[0]) ? patterns[2 + idx] : `RV32_NOP_INSTR;
        end
        // Initial RAM contents carry their own word address
        for (idx = 0; idx < RAM_WORDS; idx++) begin
            ram[idx] = 32'hda7a_0000 | (idx << 2);
        end
        prog_len = patterns[0];
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        compare_word("instr_valid", {31'b0, instr_valid}, 32'd0);
        compare_word("data_valid", {31'b0, data_valid}, 32'd0);
        while (stores_seen < store_count) begin
            @(negedge clk);
        end
        // Anything stored from here on is an extra store
        repeat (IDLE_CYCLES) @(negedge clk);
        if (rv32_core_i.protocol_chk.failures == 0) begin
            $display("All %0d expected stores seen", store_count);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("A memory port protocol assertion failed");
        end
    end

    // Watchdog sized from the program length
    initial begin
        wait (prog_len != 0);
        repeat (CYCLES_PER_WORD * prog_len) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                            CYCLES_PER_WORD * prog_len, stores_seen, store_count));
    end

endmodule

`default_nettype wire

//--- testbench/rv32_patterns.txt
// Header: program word count, expected store count
// Then one instruction word per line, then one expected store per line: address data
0000001a 00000008
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
002081b3 // add  x3, x1, x2
00302023 // sw   x3, 0(x0)
40208233 // sub  x4, x1, x2
00402223 // sw   x4, 4(x0)
001122b3 // slt  x5, x2, x1
00502423 // sw   x5, 8(x0)
12345337 // lui  x6, 0x12345
001343b3 // xor  x7, x6, x1
00702623 // sw   x7, 12(x0)
0040e433 // or   x8, x1, x4
00802823 // sw   x8, 16(x0)
00402483 // lw   x9, 4(x0)
00902a23 // sw   x9, 20(x0)
00208463 // beq  x1, x2, +8 (not taken)
00209463 // bne  x1, x2, +8 (taken)
00102c23 // sw   x1, 24(x0) skipped
00318463 // beq  x3, x3, +8 (taken)
00102e23 // sw   x1, 28(x0) skipped
0080056f // jal  x10, +8
02102023 // sw   x1, 32(x0) skipped
00a02c23 // sw   x10, 24(x0)
0083f5b3 // and  x11, x7, x8
00b02e23 // sw   x11, 28(x0)
0000006f // jal  x0, 0
00000000 00000002
00000004 00000008
00000008 00000001
0000000c 12345005
00000010 0000000d
00000014 00000008
00000018 00000054
0000001c 00000005
